// File: list.f
+incdir+verilog
verilog/xge_pkg.sv
verilog/mac_reset.sv
verilog/xgmii_tx.sv
verilog/xgmii_rx.sv
verilog/mac_host_regs.sv
verilog/xge_intf.sv
sim/tb_xge_intf.sv

// File: sim/tb_xge_intf.sv
`timescale 1ns/1ps
`include "xge_cfg.svh"

module tb_xge_intf import xge_pkg::*;;

    localparam int CLK_PERIOD  = 40;
    localparam int FRAME_COUNT = 76;        // 40 + 20 + 10 + 1 + 5 frames over all tests

    logic        clk156_25, reset, align_status, reset156_25;
    logic [63:0] mac_tx_data, mac_rx_data, xgmii_txd, xgmii_rxd;
    logic [7:0]  mac_tx_data_valid, mac_rx_data_valid, xgmii_txc, xgmii_rxc;
    logic        mac_tx_start, mac_tx_underrun, mac_tx_ack;
    logic        mac_rx_good_frame, mac_rx_bad_frame;
    host_op_t    host_opcode;
    logic [9:0]  host_addr;
    logic [31:0] host_wr_data, host_rd_data;
    logic        host_req, host_rdy;

    logic        force_idle;                // External rx input held at idle
    logic        rx_on;                     // Model view of rx_enable
    int          exp_tx, exp_good, exp_bad;
    int          exp_len_q [$];
    bit          exp_ok_q [$];
    logic [7:0]  exp_byte_q [$];
    logic [7:0]  rx_bytes [$];              // Bytes of the frame being received
    int unsigned seed_val;

    xge_intf u_xge_intf (.*);

    always #(CLK_PERIOD / 2) clk156_25 = ~clk156_25;

    // Registered wire between XGMII out and in
    always @(posedge clk156_25) begin
        xgmii_rxd <= force_idle ? {8{`XGMII_IDLE}} : xgmii_txd;
        xgmii_rxc <= force_idle ? 8'hFF : xgmii_txc;
    end

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    // Receive monitor closes one frame per strobe
    always @(posedge clk156_25) begin
        if (reset156_25 === 1'b0 && (mac_rx_data_valid != 8'h00 ||
                                     mac_rx_good_frame || mac_rx_bad_frame)) begin
            for (int i = 0; i < 8; i++)
                if (mac_rx_data_valid[i]) rx_bytes.push_back(mac_rx_data[8*i +: 8]);
            if (mac_rx_good_frame || mac_rx_bad_frame) begin
                if (exp_len_q.size() == 0)
                    report_failure("Received a frame that was never expected");
                check_value("rx frame length", rx_bytes.size(), exp_len_q.pop_front());
                foreach (rx_bytes[i])
                    check_value("mac_rx_data byte", rx_bytes[i], exp_byte_q.pop_front());
                check_value("mac_rx_good_frame", mac_rx_good_frame, exp_ok_q[0]);
                check_value("mac_rx_bad_frame", mac_rx_bad_frame, !exp_ok_q.pop_front());
                rx_bytes.delete();
            end
        end
    end

    // ------------------------------
    // Host bus and client tasks
    // ------------------------------
    task automatic host_access(input host_op_t op, input logic [9:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk156_25);
        host_opcode  <= op;
        host_addr    <= addr;
        host_wr_data <= wdata;
        host_req     <= 1'b1;
        @(posedge clk156_25);
        host_req <= 1'b0;
        @(posedge clk156_25);
        check_value("host_rdy", host_rdy, 1'b1);    // Exactly one cycle after req
        rdata = host_rd_data;
    endtask

    task automatic write_reg(input logic [9:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        host_access(HOST_WRITE, addr, wdata, unused);
    endtask

    task automatic read_reg(input string name, input logic [9:0] addr,
                            input logic [31:0] exp);
        logic [31:0] rdata;
        host_access(HOST_READ, addr, 32'd0, rdata);
        check_value(name, rdata, exp);
    endtask

    // abort_word below zero means a normal frame
    task automatic send_frame(input int len, input int abort_word);
        logic [7:0]  bytes [$];
        logic [31:0] rnd;
        logic [63:0] d;
        logic [7:0]  m;
        int          nw;
        int          w;
        bit          aborted;
        nw      = len / 8 + 1;              // Last word always has a partial mask
        aborted = 0;
        for (int b = 0; b < len; b++) begin
            rnd = $urandom;
            bytes.push_back(rnd[7:0]);
        end
        exp_tx++;
        if (rx_on) begin                    // Dropped frames leave no trace
            exp_len_q.push_back(abort_word < 0 ? len : abort_word * 8 + 8);
            exp_ok_q.push_back(abort_word < 0 && len >= `MIN_FRAME_BYTES);
            for (int b = 0; b < len && (abort_word < 0 || b < abort_word * 8); b++)
                exp_byte_q.push_back(bytes[b]);
            if (abort_word >= 0)
                repeat (8) exp_byte_q.push_back(`XGMII_ERROR);   // Error word lanes
            if (abort_word < 0 && len >= `MIN_FRAME_BYTES) exp_good++;
            else exp_bad++;
        end
        @(posedge clk156_25);
        for (w = 0; w < nw && !aborted; w++) begin
            d = '0;
            m = '0;
            for (int b = 0; b < 8; b++) begin
                if (w * 8 + b < len) begin
                    d[8*b +: 8] = bytes[w * 8 + b];
                    m[b]        = 1'b1;
                end
            end
            mac_tx_start      <= (w == 0);
            mac_tx_data       <= d;
            mac_tx_data_valid <= m;
            mac_tx_underrun   <= (w == abort_word);
            @(posedge clk156_25);
            if (w == 0) begin
                while (!mac_tx_ack) @(posedge clk156_25);   // Word 0 taken here
                // Preamble word shares the ack cycle
                check_value("xgmii_txd", xgmii_txd,
                            {`XGMII_SFD, {6{`XGMII_PREAMBLE}}, `XGMII_START});
                check_value("xgmii_txc", xgmii_txc, 8'h01);
            end
            aborted = (w == abort_word);
        end
        mac_tx_start      <= 1'b0;
        mac_tx_underrun   <= 1'b0;
        mac_tx_data_valid <= 8'h00;
        repeat ($urandom_range(4, 0)) @(posedge clk156_25);    // Random gap
    endtask

    task automatic wait_rx_drain();
        while (exp_len_q.size() != 0) @(posedge clk156_25);
        repeat (4) @(posedge clk156_25);    // Let the counters catch the last strobe
    endtask

    // Watchdog
    initial begin
        #((FRAME_COUNT * 64 + 2000) * CLK_PERIOD);
        $display("Timeout: the tests did not finish in the allowed time");
        $display("sim failed");
        $fatal(1);
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int len;
        seed_val  = $urandom(32'hb45);
        clk156_25 = 1'b0;
        reset = 1'b1;
        align_status = 1'b0;
        mac_tx_data = '0;
        mac_tx_data_valid = '0;
        mac_tx_start = 1'b0;
        mac_tx_underrun = 1'b0;
        xgmii_rxd = {8{`XGMII_IDLE}};
        xgmii_rxc = 8'hFF;
        host_opcode = HOST_READ;
        host_addr = '0;
        host_wr_data = '0;
        host_req = 1'b0;
        force_idle = 1'b0;
        rx_on = 1'b1;
        repeat (2) @(posedge clk156_25);
        reset <= 1'b0;
        repeat (3) @(posedge clk156_25);
        check_value("xgmii_txc", xgmii_txc, 8'hFF);    // Idles while MAC held
        check_value("mac_tx_ack", mac_tx_ack, 1'b0);
        align_status <= 1'b1;

        // 1. Reset release after 16 aligned cycles
        repeat (`RESET_HOLD_CYCLES) begin
            @(posedge clk156_25);
            check_value("reset156_25", reset156_25, 1'b1);
        end
        @(posedge clk156_25);
        check_value("reset156_25", reset156_25, 1'b0);
        read_reg("config", `REG_CONFIG, 32'h3);

        // 2. Good frames through the external path
        repeat (40) send_frame($urandom_range(120, 24), -1);
        wait_rx_drain();
        read_reg("tx count", `REG_TX_COUNT, 32'd40);
        read_reg("good count", `REG_GOOD_COUNT, 32'd40);

        // 3. Underrun aborts and runts
        repeat (10) begin
            len = $urandom_range(120, 24);
            send_frame(len, $urandom_range(len / 8, 1));
            send_frame($urandom_range(23, 8), -1);
        end
        wait_rx_drain();
        read_reg("bad count", `REG_BAD_COUNT, exp_bad);

        // 4. Internal loopback with the outside held idle
        force_idle <= 1'b1;
        write_reg(`REG_CONFIG, 32'h7);
        repeat (10) send_frame($urandom_range(120, 24), -1);
        wait_rx_drain();
        write_reg(`REG_CONFIG, 32'h3);
        force_idle <= 1'b0;
        read_reg("good count", `REG_GOOD_COUNT, exp_good);

        // 5. Back-pressure with tx disabled
        write_reg(`REG_CONFIG, 32'h2);
        fork
            send_frame(64, -1);
            begin
                repeat (50) begin
                    @(posedge clk156_25);
                    check_value("mac_tx_ack", mac_tx_ack, 1'b0);
                end
                write_reg(`REG_CONFIG, 32'h3);
            end
        join
        wait_rx_drain();

        // 6. Disabled rx drops frames and a counter write clears
        write_reg(`REG_CONFIG, 32'h1);
        rx_on = 1'b0;
        repeat (5) send_frame($urandom_range(120, 24), -1);
        repeat (20) @(posedge clk156_25);
        read_reg("good count", `REG_GOOD_COUNT, exp_good);
        read_reg("tx count", `REG_TX_COUNT, exp_tx);
        write_reg(`REG_GOOD_COUNT, 32'hFFFF_FFFF);
        read_reg("good count", `REG_GOOD_COUNT, 32'd0);
        if (exp_len_q.size() != 0 || rx_bytes.size() != 0) begin
            report_failure("Frames were still outstanding at the end of the run");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// File: verilog/mac_host_regs.sv
`timescale 1ns/1ps
`include "xge_cfg.svh"

module mac_host_regs import xge_pkg::*; (
    input  logic        clk156_25,
    input  logic        reset,
    input  host_op_t    host_opcode,
    input  logic [9:0]  host_addr,
    input  logic [31:0] host_wr_data,
    input  logic        host_req,
    output logic [31:0] host_rd_data,
    output logic        host_rdy,
    output logic        tx_enable,
    output logic        rx_enable,
    output logic        loopback,
    input  logic        tx_frame_done,
    input  logic        rx_good_frame,
    input  logic        rx_bad_frame
);

    // Counter addresses, index matches cnt_event
    localparam logic [9:0] CNT_ADDR [3] = '{`REG_TX_COUNT, `REG_GOOD_COUNT, `REG_BAD_COUNT};

    logic [2:0]  cfg;                       // Loopback, rx enable, tx enable
    logic [31:0] counts [3];
    logic [2:0]  cnt_event;
    logic        wr_hit;
    logic        rd_hit;
    logic [31:0] rd_mux;

    assign cnt_event = {rx_bad_frame, rx_good_frame, tx_frame_done};
    assign wr_hit    = host_req && (host_opcode == HOST_WRITE);
    assign rd_hit    = host_req && (host_opcode == HOST_READ);
    assign tx_enable = cfg[0];
    assign rx_enable = cfg[1];
    assign loopback  = cfg[2];

    // Read decode, unknown addresses give zero
    always_comb begin
        rd_mux = '0;
        if (host_addr == `REG_CONFIG)
            rd_mux = {29'd0, cfg};
        for (int k = 0; k < 3; k++)
            if (host_addr == CNT_ADDR[k]) rd_mux = counts[k];
    end

    always_ff @(posedge clk156_25) begin
        if (reset) begin
            cfg      <= 3'b011;             // Both paths on, no loopback
            host_rdy <= 1'b0;
            for (int k = 0; k < 3; k++) counts[k] <= '0;
        end else begin
            host_rdy <= wr_hit || rd_hit;   // One cycle after the request
            if (wr_hit && (host_addr == `REG_CONFIG))
                cfg <= host_wr_data[2:0];
            for (int k = 0; k < 3; k++) begin
                if (wr_hit && (host_addr == CNT_ADDR[k]))
                    counts[k] <= '0;        // Any write clears
                else if (cnt_event[k])
                    counts[k] <= counts[k] + 32'd1;   // Wraps
            end
        end
    end

    always_ff @(posedge clk156_25) begin
        host_rd_data <= rd_hit ? rd_mux : '0;
    end

endmodule

// File: verilog/mac_reset.sv
`timescale 1ns/1ps
`include "xge_cfg.svh"

module mac_reset (
    input  logic clk156_25,
    input  logic reset,
    input  logic align_status,           // Lane alignment from the PHY side
    output logic reset156_25
);

    localparam int CNT_W = $clog2(`RESET_HOLD_CYCLES + 1);

    logic [CNT_W-1:0] align_cnt;         // Consecutive aligned cycles
    logic [CNT_W-1:0] align_cnt_nxt;

    // Saturate at the hold count
    assign align_cnt_nxt = (align_cnt == CNT_W'(`RESET_HOLD_CYCLES)) ?
                           align_cnt : align_cnt + 1'b1;

    always_ff @(posedge clk156_25) begin
        if (reset || !align_status) begin
            align_cnt   <= '0;           // Alignment lost, start over
            reset156_25 <= 1'b1;
        end else begin
            align_cnt   <= align_cnt_nxt;
            // Release once the count completes
            reset156_25 <= (align_cnt_nxt != CNT_W'(`RESET_HOLD_CYCLES));
        end
    end

endmodule

// File: verilog/xge_cfg.svh
`ifndef XGE_CFG_SVH
`define XGE_CFG_SVH

// ------------------------------
// XGMII control characters
// ------------------------------
`define XGMII_IDLE        8'h07
`define XGMII_START       8'hFB
`define XGMII_TERM        8'hFD
`define XGMII_ERROR       8'hFE
`define XGMII_PREAMBLE    8'h55
`define XGMII_SFD         8'hD5

// Link and framing limits
`define RESET_HOLD_CYCLES 16      // Aligned cycles before MAC reset release
`define IFG_WORDS         2       // Idle words between frames
`define MIN_FRAME_BYTES   24      // Shorter frames are runts

// Host register map
`define REG_CONFIG        10'h000
`define REG_TX_COUNT      10'h004
`define REG_GOOD_COUNT    10'h008
`define REG_BAD_COUNT     10'h00C

`endif

// File: verilog/xge_intf.sv
`timescale 1ns/1ps

module xge_intf import xge_pkg::*; (
    // Clock and reset
    input  logic        clk156_25,
    input  logic        reset,
    input  logic        align_status,
    output logic        reset156_25,

    // MAC tx
    input  logic [63:0] mac_tx_data,
    input  logic [7:0]  mac_tx_data_valid,
    input  logic        mac_tx_start,
    input  logic        mac_tx_underrun,
    output logic        mac_tx_ack,

    // MAC rx
    output logic [63:0] mac_rx_data,
    output logic [7:0]  mac_rx_data_valid,
    output logic        mac_rx_good_frame,
    output logic        mac_rx_bad_frame,

    // XGMII
    output logic [63:0] xgmii_txd,
    output logic [7:0]  xgmii_txc,
    input  logic [63:0] xgmii_rxd,
    input  logic [7:0]  xgmii_rxc,

    // Host bus
    input  host_op_t    host_opcode,
    input  logic [9:0]  host_addr,
    input  logic [31:0] host_wr_data,
    input  logic        host_req,
    output logic [31:0] host_rd_data,
    output logic        host_rdy
);

    logic        tx_enable;
    logic        rx_enable;
    logic        loopback;
    logic        tx_frame_done;
    logic [63:0] rx_d;                      // Decoder input after loopback mux
    logic [7:0]  rx_c;

    // ------------------------------
    // Internal loopback
    // ------------------------------
    assign rx_d = loopback ? xgmii_txd : xgmii_rxd;
    assign rx_c = loopback ? xgmii_txc : xgmii_rxc;

    mac_reset u_mac_reset (
        .clk156_25(clk156_25), .reset(reset),
        .align_status(align_status), .reset156_25(reset156_25)
    );

    xgmii_tx u_xgmii_tx (
        .clk156_25(clk156_25), .reset156_25(reset156_25), .tx_enable(tx_enable),
        .mac_tx_data(mac_tx_data), .mac_tx_data_valid(mac_tx_data_valid),
        .mac_tx_start(mac_tx_start), .mac_tx_underrun(mac_tx_underrun),
        .mac_tx_ack(mac_tx_ack), .xgmii_txd(xgmii_txd), .xgmii_txc(xgmii_txc),
        .tx_frame_done(tx_frame_done)
    );

    xgmii_rx u_xgmii_rx (
        .clk156_25(clk156_25), .reset156_25(reset156_25), .rx_enable(rx_enable),
        .xgmii_rxd(rx_d), .xgmii_rxc(rx_c),
        .mac_rx_data(mac_rx_data), .mac_rx_data_valid(mac_rx_data_valid),
        .mac_rx_good_frame(mac_rx_good_frame), .mac_rx_bad_frame(mac_rx_bad_frame)
    );

    // Registers run on the board reset, not the link-gated one
    mac_host_regs u_mac_host_regs (
        .clk156_25(clk156_25), .reset(reset),
        .host_opcode(host_opcode), .host_addr(host_addr),
        .host_wr_data(host_wr_data), .host_req(host_req),
        .host_rd_data(host_rd_data), .host_rdy(host_rdy),
        .tx_enable(tx_enable), .rx_enable(rx_enable), .loopback(loopback),
        .tx_frame_done(tx_frame_done),
        .rx_good_frame(mac_rx_good_frame), .rx_bad_frame(mac_rx_bad_frame)
    );

endmodule

// File: verilog/xge_pkg.sv
package xge_pkg;

    // ------------------------------
    // Transmit encoder states
    // ------------------------------
    typedef enum logic [2:0] {
        TX_IDLE     = 3'd0,             // Idles, waiting for a client start
        TX_PREAMBLE = 3'd1,             // Ack cycle, preamble word on the bus
        TX_DATA     = 3'd2,             // Client words streaming
        TX_TERM     = 3'd3,             // Terminate word after an error word
        TX_GAP      = 3'd4              // Interframe idles
    } tx_state_t;

    // Receive decoder states
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_FRAME = 2'd1,                // Passing data up to the client
        RX_DROP  = 2'd2                 // Discarding until terminate
    } rx_state_t;

    // Host bus opcodes, other codes ignored
    typedef enum logic [1:0] {
        HOST_WRITE = 2'd1,
        HOST_READ  = 2'd2
    } host_op_t;

endpackage

// File: verilog/xgmii_rx.sv
`timescale 1ns/1ps
`include "xge_cfg.svh"

module xgmii_rx import xge_pkg::*; (
    input  logic        clk156_25,
    input  logic        reset156_25,
    input  logic        rx_enable,          // Sampled at the start word
    input  logic [63:0] xgmii_rxd,
    input  logic [7:0]  xgmii_rxc,
    output logic [63:0] mac_rx_data,
    output logic [7:0]  mac_rx_data_valid,
    output logic        mac_rx_good_frame,
    output logic        mac_rx_bad_frame
);

    rx_state_t  state;
    logic [7:0] byte_cnt;                   // Stops growing past the runt limit
    logic [7:0] frame_bytes;                // Count including the last word
    logic       frame_err;                  // Error char seen earlier in frame
    logic       start_hit;
    logic       term_hit;
    logic [2:0] term_lane;
    logic       err_hit;
    logic [7:0] lane_mask;                  // Data lanes of this word

    assign start_hit   = xgmii_rxc[0] && (xgmii_rxd[7:0] == `XGMII_START);
    assign frame_bytes = byte_cnt + {5'd0, term_lane};

    // ------------------------------
    // Lane decode
    // ------------------------------
    always_comb begin
        term_hit  = 1'b0;
        term_lane = 3'd0;
        err_hit   = 1'b0;
        lane_mask = 8'h00;
        for (int i = 7; i >= 0; i--) begin  // Downward, lowest terminate wins
            if (xgmii_rxc[i] && (xgmii_rxd[8*i +: 8] == `XGMII_TERM)) begin
                term_hit  = 1'b1;
                term_lane = 3'(i);
            end
        end
        for (int i = 0; i < 8; i++) begin
            if (!term_hit || (i < int'(term_lane))) begin
                lane_mask[i] = 1'b1;
                if (xgmii_rxc[i] && (xgmii_rxd[8*i +: 8] == `XGMII_ERROR))
                    err_hit = 1'b1;
            end
        end
    end

    // Data word lags the XGMII word by one cycle
    always_ff @(posedge clk156_25) begin
        mac_rx_data <= xgmii_rxd;
    end

    // ------------------------------
    // Decoder FSM
    // ------------------------------
    always_ff @(posedge clk156_25) begin
        if (reset156_25) begin
            state             <= RX_IDLE;
            byte_cnt          <= '0;
            frame_err         <= 1'b0;
            mac_rx_data_valid <= 8'h00;
            mac_rx_good_frame <= 1'b0;
            mac_rx_bad_frame  <= 1'b0;
        end else begin
            mac_rx_data_valid <= 8'h00;
            mac_rx_good_frame <= 1'b0;
            mac_rx_bad_frame  <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (start_hit) begin        // Preamble word is stripped
                        byte_cnt  <= '0;
                        frame_err <= 1'b0;
                        state     <= rx_enable ? RX_FRAME : RX_DROP;
                    end
                end
                RX_FRAME: begin
                    mac_rx_data_valid <= lane_mask;
                    if (term_hit) begin
                        state <= RX_IDLE;
                        if (frame_err || err_hit || (frame_bytes < `MIN_FRAME_BYTES))
                            mac_rx_bad_frame <= 1'b1;
                        else
                            mac_rx_good_frame <= 1'b1;
                    end else begin
                        frame_err <= frame_err | err_hit;
                        if (byte_cnt < `MIN_FRAME_BYTES)
                            byte_cnt <= byte_cnt + 8'd8;
                    end
                end
                RX_DROP: if (term_hit) state <= RX_IDLE;    // No strobes
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/xgmii_tx.sv
`timescale 1ns/1ps
`include "xge_cfg.svh"

module xgmii_tx import xge_pkg::*; (
    input  logic        clk156_25,
    input  logic        reset156_25,
    input  logic        tx_enable,          // Back-pressure from the config register
    input  logic [63:0] mac_tx_data,
    input  logic [7:0]  mac_tx_data_valid,
    input  logic        mac_tx_start,
    input  logic        mac_tx_underrun,
    output logic        mac_tx_ack,
    output logic [63:0] xgmii_txd,
    output logic [7:0]  xgmii_txc,
    output logic        tx_frame_done       // One pulse per finished frame
);

    localparam int GAP_W = $clog2(`IFG_WORDS + 1);

    tx_state_t        state;
    logic [GAP_W-1:0] gap_cnt;              // Idle words since last terminate
    logic [63:0]      word_d;               // Client word with terminate merged in
    logic [7:0]       word_c;
    logic             word_last;            // Mask not full so the frame ends here

    assign word_last = (mac_tx_data_valid != 8'hFF);

    // ------------------------------
    // Lane builder
    // ------------------------------
    always_comb begin
        logic prev_valid;
        prev_valid = 1'b1;                  // Lane 0 may hold the terminate
        for (int i = 0; i < 8; i++) begin
            if (mac_tx_data_valid[i]) begin
                word_d[8*i +: 8] = mac_tx_data[8*i +: 8];
                word_c[i]        = 1'b0;
            end else if (prev_valid) begin
                word_d[8*i +: 8] = `XGMII_TERM;  // First invalid lane
                word_c[i]        = 1'b1;
            end else begin
                word_d[8*i +: 8] = `XGMII_IDLE;
                word_c[i]        = 1'b1;
            end
            prev_valid = mac_tx_data_valid[i];
        end
    end

    // ------------------------------
    // Encoder FSM
    // ------------------------------
    always_ff @(posedge clk156_25) begin
        if (reset156_25) begin
            state         <= TX_IDLE;
            gap_cnt       <= '0;
            mac_tx_ack    <= 1'b0;
            tx_frame_done <= 1'b0;
            xgmii_txd     <= {8{`XGMII_IDLE}};
            xgmii_txc     <= 8'hFF;
        end else begin
            mac_tx_ack    <= 1'b0;
            tx_frame_done <= 1'b0;
            xgmii_txd     <= {8{`XGMII_IDLE}};  // Idles unless overridden
            xgmii_txc     <= 8'hFF;
            case (state)
                TX_IDLE: begin
                    if (tx_enable && mac_tx_start) begin
                        mac_tx_ack <= 1'b1;
                        // Start in lane 0 and SFD in lane 7
                        xgmii_txd  <= {`XGMII_SFD, {6{`XGMII_PREAMBLE}}, `XGMII_START};
                        xgmii_txc  <= 8'h01;
                        state      <= TX_PREAMBLE;
                    end
                end
                TX_PREAMBLE, TX_DATA: begin
                    if (mac_tx_underrun) begin
                        xgmii_txd <= {8{`XGMII_ERROR}};   // Abort word
                        state     <= TX_TERM;
                    end else begin
                        xgmii_txd <= word_d;
                        xgmii_txc <= word_c;
                        if (word_last) begin
                            tx_frame_done <= 1'b1;
                            gap_cnt       <= '0;
                            state         <= TX_GAP;
                        end else begin
                            state <= TX_DATA;
                        end
                    end
                end
                TX_TERM: begin
                    xgmii_txd     <= {{7{`XGMII_IDLE}}, `XGMII_TERM};
                    tx_frame_done <= 1'b1;              // Aborted frames count too
                    gap_cnt       <= '0;
                    state         <= TX_GAP;
                end
                TX_GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == GAP_W'(`IFG_WORDS - 1))
                        state <= TX_IDLE;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule
